/* design/mem_pkg.sv */
package mem_pkg;

	////////////////////
	// Bus widths
	////////////////////

	// Wishbone and SRAM word address
	localparam int ADDR_W = 18;

	// Shared SRAM / UART data bus and Wishbone data
	localparam int DATA_W = 16;

	////////////////////
	// Address map
	////////////////////

	// Everything else falls through to SRAM
	localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 18'h0BF00;
	localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 18'h0BF01;

	////////////////////
	// Strobe timing
	////////////////////

	// Clock cycles per bus phase
	localparam int STROBE_CYCLES = 2;

	// Width of the phase counter
	localparam int PHASE_W = (STROBE_CYCLES > 1) ? $clog2(STROBE_CYCLES) : 1;

endpackage

/* design/uart_pkg.sv */
package uart_pkg;

	////////////////////
	// Byte and queue
	////////////////////

	// Byte width of the UART chip
	localparam int BYTE_W = 8;

	// Receive queue entries
	localparam int QUEUE_DEPTH = 8;
	localparam int QPTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	////////////////////
	// Status register
	////////////////////

	// Receive queue holds at least one byte
	localparam int STAT_RX_VALID = 0;

	// Both transmitter empty flags high
	localparam int STAT_TX_IDLE = 1;

endpackage

/* design/wb_if.sv */
`timescale 1ns/1ps

interface wb_if;
	import mem_pkg::*;

	// Cycle framing
	logic cyc;
	logic stb;
	logic we;

	// Address and data
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;
	logic [DATA_W-1:0] dat_r;

	// Single cycle acknowledge
	logic ack;

	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		output dat_r,
		output ack
	);

endinterface

/* design/rxq_if.sv */
`timescale 1ns/1ps

interface rxq_if;
	import uart_pkg::*;

	// Write side
	logic push;
	logic [BYTE_W-1:0] push_data;
	logic full;

	// Read side with the oldest entry on front_data
	logic pop;
	logic [BYTE_W-1:0] front_data;
	logic empty;

	modport producer (
		output push,
		output push_data,
		input  full
	);

	modport consumer (
		output pop,
		input  front_data,
		input  empty
	);

	modport queue (
		input  push,
		input  push_data,
		output full,
		input  pop,
		output front_data,
		output empty
	);

endinterface

/* design/rx_queue.sv */
`timescale 1ns/1ps

module rx_queue (
	input logic clk,
	input logic tbre,
	rxq_if.queue q
);
	import uart_pkg::*;

	logic [BYTE_W-1:0] mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] head;
	logic [QPTR_W-1:0] tail;
	logic [QPTR_W:0] count;
	logic do_push;
	logic do_pop;

	// Requests against the wrong flag are dropped
	assign do_push = q.push && !q.full;
	assign do_pop = q.pop && !q.empty;

	assign q.full = (count == (QPTR_W+1)'(QUEUE_DEPTH));
	assign q.empty = (count == '0);
	assign q.front_data = mem[head];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail] <= q.push_data;
		end
	end

	////////////////////
	// Pointers
	////////////////////

	always_ff @(posedge clk or posedge tbre) begin
		if (tbre) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				if (tail == QPTR_W'(QUEUE_DEPTH - 1))
					tail <= '0;
				else
					tail <= tail + 1'b1;
			end
			if (do_pop) begin
				if (head == QPTR_W'(QUEUE_DEPTH - 1))
					head <= '0;
				else
					head <= head + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Checks
	////////////////////

	// The sequencer holds off receive while full, so a push never meets a full queue
	a_no_push_full: assert property (@(posedge clk) disable iff (tbre)
		q.push |-> !q.full)
		else $error("rx_queue: push while full");

	// Data reads of an empty queue return zero without a pop
	a_no_pop_empty: assert property (@(posedge clk) disable iff (tbre)
		q.pop |-> !q.empty)
		else $error("rx_queue: pop while empty");

endmodule

/* design/bus_sequencer.sv */
`timescale 1ns/1ps

module bus_sequencer (
	input  logic clk,
	input  logic tbre,
	wb_if.slave wb,
	rxq_if.producer rxq_prod,
	rxq_if.consumer rxq_cons,
	output logic [mem_pkg::ADDR_W-1:0] ram_addr,
	inout  wire  [mem_pkg::DATA_W-1:0] ram_data,
	output logic ram_en_n,
	output logic ram_oe_n,
	output logic ram_we_n,
	output logic uart_rd_n,
	output logic uart_wr_n,
	input  logic uart_data_ready,
	input  logic uart_tx_buf_empty,
	input  logic uart_tx_shift_empty
);
	import mem_pkg::*;
	import uart_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_RD_EN,
		S_RD_OE,
		S_RD_CAP,
		S_WR_EN,
		S_WR_PULSE,
		S_WR_REL,
		S_TX_DRV,
		S_TX_PULSE,
		S_TX_WAIT,
		S_QRD,
		S_STAT,
		S_DONE,
		S_RX_PUSH,
		S_RX_HOLD
	} state_t;

	state_t state;
	state_t state_next;
	logic [PHASE_W-1:0] phase;
	logic phase_last;
	logic finish;
	logic wb_req;
	logic rx_ready;
	logic tx_idle;
	logic drive_bus;
	logic [DATA_W-1:0] stat_word;

	assign phase_last = (phase == PHASE_W'(STROBE_CYCLES - 1));
	assign tx_idle = uart_tx_buf_empty && uart_tx_shift_empty;

	// Skip the ack cycle so a held request is not taken twice
	assign wb_req = wb.cyc && wb.stb && !wb.ack;
	assign rx_ready = uart_data_ready && !rxq_prod.full;

	assign ram_addr = wb.adr;
	assign ram_data = drive_bus ? wb.dat_w : 'z;

	always_comb begin
		stat_word = '0;
		stat_word[STAT_RX_VALID] = !rxq_cons.empty;
		stat_word[STAT_TX_IDLE] = tx_idle;
	end

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		state_next = state;
		finish = 1'b0;
		case (state)
			S_IDLE: begin
				// Receive wins over a waiting request
				if (rx_ready)
					state_next = S_RX_PUSH;
				else if (wb_req) begin
					if (wb.adr == UART_STAT_ADDR)
						state_next = S_STAT;
					else if (wb.adr == UART_DATA_ADDR)
						state_next = wb.we ? S_TX_DRV : S_QRD;
					else
						state_next = wb.we ? S_WR_EN : S_RD_EN;
				end
			end
			S_RD_EN:    if (phase_last) state_next = S_RD_OE;
			S_RD_OE:    if (phase_last) state_next = S_RD_CAP;
			S_WR_EN:    if (phase_last) state_next = S_WR_PULSE;
			S_WR_PULSE: if (phase_last) state_next = S_WR_REL;
			S_TX_DRV:   if (phase_last) state_next = S_TX_PULSE;
			S_TX_PULSE: if (phase_last) state_next = S_TX_WAIT;
			S_RX_PUSH:  if (phase_last) state_next = S_RX_HOLD;
			S_RX_HOLD:  if (phase_last) state_next = S_IDLE;
			S_RD_CAP, S_WR_REL: begin
				if (phase_last) begin
					state_next = S_IDLE;
					finish = 1'b1;
				end
			end
			S_TX_WAIT: begin
				// Flags are sampled at phase ends only, giving the chip time to drop them
				if (phase_last && tx_idle) begin
					state_next = S_IDLE;
					finish = 1'b1;
				end
			end
			S_QRD, S_STAT: state_next = S_DONE;
			S_DONE: begin
				state_next = S_IDLE;
				finish = 1'b1;
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge tbre) begin
		if (tbre) begin
			state <= S_IDLE;
			phase <= '0;
			wb.ack <= 1'b0;
		end else begin
			state <= state_next;
			if (state_next != state || phase_last)
				phase <= '0;
			else
				phase <= phase + 1'b1;
			wb.ack <= finish;
		end
	end

	// Read results
	always_ff @(posedge clk) begin
		case (state)
			S_RD_CAP: if (phase_last) wb.dat_r <= ram_data;
			S_QRD: begin
				if (rxq_cons.empty)
					wb.dat_r <= '0;
				else
					wb.dat_r <= {{(DATA_W-BYTE_W){1'b0}}, rxq_cons.front_data};
			end
			S_STAT: wb.dat_r <= stat_word;
			default: wb.dat_r <= wb.dat_r;
		endcase
	end

	////////////////////
	// Strobes
	////////////////////

	always_comb begin
		ram_en_n = !(state inside {S_RD_EN, S_RD_OE, S_RD_CAP, S_WR_EN, S_WR_PULSE, S_WR_REL});
		ram_oe_n = !(state inside {S_RD_OE, S_RD_CAP});
		ram_we_n = (state != S_WR_PULSE);
		uart_wr_n = (state != S_TX_PULSE);
		uart_rd_n = !(state inside {S_RX_PUSH, S_RX_HOLD});
		drive_bus = state inside {S_WR_EN, S_WR_PULSE, S_WR_REL,
			S_TX_DRV, S_TX_PULSE, S_TX_WAIT};
	end

	// Low byte goes in at the end of the first rd_n phase
	assign rxq_prod.push = (state == S_RX_PUSH) && phase_last;
	assign rxq_prod.push_data = ram_data[BYTE_W-1:0];
	assign rxq_cons.pop = (state == S_QRD) && !rxq_cons.empty;

	////////////////////
	// Checks
	////////////////////

	a_ram_oe_we: assert property (@(posedge clk) disable iff (tbre)
		!(!ram_oe_n && !ram_we_n))
		else $error("bus_sequencer: ram_oe_n and ram_we_n low together");

	a_uart_rd_wr: assert property (@(posedge clk) disable iff (tbre)
		!(!uart_rd_n && !uart_wr_n))
		else $error("bus_sequencer: uart_rd_n and uart_wr_n low together");

	// Board drives the bus under either read strobe
	a_bus_contention: assert property (@(posedge clk) disable iff (tbre)
		drive_bus |-> (ram_oe_n && uart_rd_n))
		else $error("bus_sequencer: bus driven during a read strobe");

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (tbre)
		wb.ack |-> (wb.cyc && wb.stb))
		else $error("bus_sequencer: ack outside a bus cycle");

endmodule

/* design/mem_uart_top.sv */
`timescale 1ns/1ps

module mem_uart_top (
	input  logic clk,
	input  logic tbre,

	// Wishbone classic slave port
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [mem_pkg::ADDR_W-1:0] wb_adr,
	input  logic [mem_pkg::DATA_W-1:0] wb_dat_w,
	output logic [mem_pkg::DATA_W-1:0] wb_dat_r,
	output logic wb_ack,

	// SRAM and UART chip on the shared bus
	output logic [mem_pkg::ADDR_W-1:0] ram_addr,
	inout  wire  [mem_pkg::DATA_W-1:0] ram_data,
	output logic ram_en_n,
	output logic ram_oe_n,
	output logic ram_we_n,
	output logic uart_rd_n,
	output logic uart_wr_n,
	input  logic uart_data_ready,
	input  logic uart_tx_buf_empty,
	input  logic uart_tx_shift_empty
);

	wb_if wb ();
	rxq_if rxq ();

	assign wb.cyc = wb_cyc;
	assign wb.stb = wb_stb;
	assign wb.we = wb_we;
	assign wb.adr = wb_adr;
	assign wb.dat_w = wb_dat_w;
	assign wb_dat_r = wb.dat_r;
	assign wb_ack = wb.ack;

	rx_queue u_queue (
		.clk (clk),
		.tbre(tbre),
		.q   (rxq.queue)
	);

	bus_sequencer u_seq (
		.clk                (clk),
		.tbre               (tbre),
		.wb                 (wb.slave),
		.rxq_prod           (rxq.producer),
		.rxq_cons           (rxq.consumer),
		.ram_addr           (ram_addr),
		.ram_data           (ram_data),
		.ram_en_n           (ram_en_n),
		.ram_oe_n           (ram_oe_n),
		.ram_we_n           (ram_we_n),
		.uart_rd_n          (uart_rd_n),
		.uart_wr_n          (uart_wr_n),
		.uart_data_ready    (uart_data_ready),
		.uart_tx_buf_empty  (uart_tx_buf_empty),
		.uart_tx_shift_empty(uart_tx_shift_empty)
	);

endmodule

/* verif/board_model.sv */
`timescale 1ns/1ps

module board_model (
	input  logic clk,
	input  logic [mem_pkg::ADDR_W-1:0] ram_addr,
	inout  wire  [mem_pkg::DATA_W-1:0] ram_data,
	input  logic ram_en_n,
	input  logic ram_oe_n,
	input  logic ram_we_n,
	input  logic uart_rd_n,
	input  logic uart_wr_n,
	output logic uart_data_ready,
	output logic uart_tx_buf_empty,
	output logic uart_tx_shift_empty
);
	import mem_pkg::*;
	import uart_pkg::*;

	// Shift register drains this many cycles after the holding buffer
	localparam int SHIFT_CYCLES = 3;

	logic [DATA_W-1:0] sram [0:(1 << ADDR_W) - 1];
	logic [BYTE_W-1:0] rx_list [$];
	logic [BYTE_W-1:0] tx_log [$];
	logic [BYTE_W-1:0] rx_front;
	int rx_left;
	int tx_pulses;
	int tx_delay;
	int tx_busy;
	logic tx_hold;
	logic wr_prev;

	// Power-up contents depend on every address bit
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
		return DATA_W'(a) ^ (DATA_W'(a >> DATA_W) * 16'h3B1D) ^ 16'h5A3C;
	endfunction

	function automatic void refresh_rx();
		rx_left = rx_list.size();
		rx_front = (rx_left > 0) ? rx_list[0] : '0;
	endfunction

	initial begin
		rx_front = '0;
		rx_left = 0;
		tx_pulses = 0;
		tx_delay = 0;
		tx_busy = 0;
		tx_hold = 1'b0;
		wr_prev = 1'b1;
		for (int a = 0; a < (1 << ADDR_W); a++)
			sram[a] = fill_word(ADDR_W'(a));
	end

	////////////////////
	// Shared bus
	////////////////////

	assign ram_data = (!ram_en_n && !ram_oe_n) ? sram[ram_addr] :
		(!uart_rd_n ? DATA_W'(rx_front) : 'z);

	assign uart_data_ready = (rx_left > 0);
	assign uart_tx_buf_empty = !tx_hold && (tx_busy <= SHIFT_CYCLES);
	assign uart_tx_shift_empty = !tx_hold && (tx_busy == 0);

	always @(posedge clk) begin
		if (!ram_en_n && !ram_we_n)
			sram[ram_addr] <= ram_data;
	end

	// Byte is taken at the start of the wr_n pulse
	always @(posedge clk) begin
		wr_prev <= uart_wr_n;
		if (wr_prev && !uart_wr_n) begin
			tx_log.push_back(ram_data[BYTE_W-1:0]);
			tx_pulses <= tx_pulses + 1;
			tx_busy <= tx_delay + SHIFT_CYCLES;
		end else if (tx_busy > 0) begin
			tx_busy <= tx_busy - 1;
		end
	end

	// Chip drops the byte when rd_n returns high
	always @(posedge uart_rd_n) begin
		if (rx_left > 0) begin
			void'(rx_list.pop_front());
			refresh_rx();
		end
	end

	task automatic inject_byte(input logic [BYTE_W-1:0] b);
		rx_list.push_back(b);
		refresh_rx();
	endtask

	task automatic take_tx_byte(output logic [BYTE_W-1:0] b, output bit found);
		found = (tx_log.size() > 0);
		if (found)
			b = tx_log.pop_front();
		else
			b = '0;
	endtask

	task automatic set_tx_delay(input int cycles);
		tx_delay = cycles;
	endtask

	// Holds both empty flags low
	task automatic set_tx_hold(input logic hold);
		tx_hold = hold;
	endtask

endmodule

/* verif/tb_mem_uart.sv */
`timescale 1ns/1ps

module tb_mem_uart;
	import mem_pkg::*;
	import uart_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int SRAM_WORDS = 20;
	localparam int TX_OPS = 10;
	localparam int TX_DELAY_MAX = 12;
	localparam int EXTRA_BYTES = 3;
	localparam int RX_BYTES = 5 + 1 + QUEUE_DEPTH + EXTRA_BYTES;
	localparam int REG_READS = 30;
	localparam int HANDSHAKE = 4;
	localparam int IDLE_CYCLES = 100;

	// Worst case per operation with half again on top
	localparam int SRAM_LAT = 3 * STROBE_CYCLES + HANDSHAKE;
	localparam int TX_LAT = 4 * STROBE_CYCLES + TX_DELAY_MAX + 3 + HANDSHAKE;
	localparam int RX_LAT = 2 * STROBE_CYCLES + HANDSHAKE;
	localparam int REG_LAT = 2 + HANDSHAKE;
	localparam int CYCLE_LIMIT = (3 * (RESET_CYCLES + IDLE_CYCLES + 2 * SRAM_WORDS * SRAM_LAT
		+ TX_OPS * TX_LAT + RX_BYTES * RX_LAT + REG_READS * REG_LAT)) / 2;

	logic clk;
	logic tbre;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [ADDR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_w, wb_dat_r;
	logic [ADDR_W-1:0] ram_addr;
	wire  [DATA_W-1:0] ram_data;
	logic ram_en_n, ram_oe_n, ram_we_n, uart_rd_n, uart_wr_n;
	logic uart_data_ready, uart_tx_buf_empty, uart_tx_shift_empty;

	int value_errors = 0;
	int protocol_errors = 0;
	int cycle_count;
	string test_name = "reset";
	logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
	logic [ADDR_W-1:0] addr_list [SRAM_WORDS];
	logic [BYTE_W-1:0] expected_rx [$];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	mem_uart_top u_dut (.*);
	board_model u_board (.*);

	task automatic report_protocol_error(input string what);
		protocol_errors++;
		$display("[ERROR] %s: %s at %0t", test_name, what, $time);
	endtask

	task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		assert (actual === expected)
		else begin
			value_errors++;
			$display("[ERROR] %s: %s expected 0x%h actual 0x%h",
				test_name, what, expected, actual);
		end
	endtask

	function automatic logic [DATA_W-1:0] status_word(input logic rx_valid, input logic tx_idle);
		logic [DATA_W-1:0] w;
		w = '0;
		w[STAT_RX_VALID] = rx_valid;
		w[STAT_TX_IDLE] = tx_idle;
		return w;
	endfunction

	////////////////////
	// Bus safety
	////////////////////

	a_reset_strobes: assert property (@(posedge clk)
		tbre |=> (ram_en_n && ram_oe_n && ram_we_n && uart_rd_n && uart_wr_n))
		else report_protocol_error("a strobe is low during reset");

	a_strobe_conflict: assert property (@(posedge clk) disable iff (tbre)
		!(!ram_oe_n && !ram_we_n) && !(!uart_rd_n && !uart_wr_n) && !(!ram_oe_n && !uart_rd_n))
		else report_protocol_error("two conflicting strobes are low together");

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (tbre)
		wb_ack |-> (wb_cyc && wb_stb))
		else report_protocol_error("wb_ack is high outside a bus cycle");

	a_tx_ack_idle: assert property (@(posedge clk) disable iff (tbre)
		(wb_ack && wb_we && wb_adr == UART_DATA_ADDR) |->
		(uart_tx_buf_empty && uart_tx_shift_empty))
		else report_protocol_error("UART write acknowledged while the transmitter is busy");

	// Request held until ack and dropped one cycle later
	task automatic run_cycle(input logic we, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdat);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		while (wb_ack !== 1'b1)
			@(negedge clk);
		rdat = wb_dat_r;
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] ignored;
		run_cycle(1'b1, adr, dat, ignored);
	endtask

	task automatic read_word(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rdat);
		run_cycle(1'b0, adr, '0, rdat);
	endtask

	task automatic send_to_uart(input logic [BYTE_W-1:0] b);
		@(negedge clk);
		u_board.inject_byte(b);
		expected_rx.push_back(b);
	endtask

	task automatic wait_rx_left(input int left);
		while (u_board.rx_left > left || uart_rd_n !== 1'b1)
			@(negedge clk);
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] rdat, wdat;
		logic [ADDR_W-1:0] adr;
		logic [BYTE_W-1:0] txb, exp_byte;
		bit found;
		int pulses_before;

		void'($urandom(23943));
		tbre = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		tbre = 1'b0;

		test_name = "sram_round_trip";
		for (int i = 0; i < SRAM_WORDS; i++) begin
			adr = ADDR_W'($urandom);
			if (adr == UART_DATA_ADDR || adr == UART_STAT_ADDR)
				adr = adr ^ 18'h20000;
			wdat = DATA_W'($urandom);
			addr_list[i] = adr;
			shadow[adr] = wdat;
			write_word(adr, wdat);
		end
		for (int i = 0; i < SRAM_WORDS; i++) begin
			read_word(addr_list[i], rdat);
			check_value($sformatf("read of 0x%h", addr_list[i]), shadow[addr_list[i]], rdat);
		end

		test_name = "uart_transmit";
		for (int i = 0; i < TX_OPS; i++) begin
			wdat = DATA_W'($urandom);
			u_board.set_tx_delay($urandom_range(TX_DELAY_MAX, 0));
			pulses_before = u_board.tx_pulses;
			write_word(UART_DATA_ADDR, wdat);
			check_value("wr_n pulses", 1, DATA_W'(u_board.tx_pulses - pulses_before));
			u_board.take_tx_byte(txb, found);
			check_value("logged byte", DATA_W'(wdat[BYTE_W-1:0]),
				found ? DATA_W'(txb) : {DATA_W{1'bx}});
		end

		test_name = "receive_order";
		for (int i = 0; i < 5; i++)
			send_to_uart(BYTE_W'($urandom));
		wait_rx_left(0);
		for (int i = 0; i < 5; i++) begin
			read_word(UART_DATA_ADDR, rdat);
			exp_byte = expected_rx.pop_front();
			check_value($sformatf("byte %0d", i), DATA_W'(exp_byte), rdat);
		end
		read_word(UART_DATA_ADDR, rdat);
		check_value("read of empty queue", '0, rdat);

		test_name = "status_register";
		read_word(UART_STAT_ADDR, rdat);
		check_value("idle status", status_word(1'b0, 1'b1), rdat);
		send_to_uart(8'hA5);
		wait_rx_left(0);
		read_word(UART_STAT_ADDR, rdat);
		check_value("byte waiting", status_word(expected_rx.size() > 0, 1'b1), rdat);
		u_board.set_tx_hold(1'b1);
		read_word(UART_STAT_ADDR, rdat);
		check_value("transmitter busy", status_word(expected_rx.size() > 0, 1'b0), rdat);
		u_board.set_tx_hold(1'b0);
		read_word(UART_DATA_ADDR, rdat);
		exp_byte = expected_rx.pop_front();
		check_value("waiting byte", DATA_W'(exp_byte), rdat);
		read_word(UART_STAT_ADDR, rdat);
		check_value("status after read", status_word(expected_rx.size() > 0, 1'b1), rdat);

		test_name = "back_pressure";
		for (int i = 0; i < QUEUE_DEPTH + EXTRA_BYTES; i++)
			send_to_uart(BYTE_W'($urandom));
		wait_rx_left(EXTRA_BYTES);
		repeat (20) @(negedge clk);
		check_value("bytes held in the chip", EXTRA_BYTES, DATA_W'(u_board.rx_left));
		for (int i = 0; i < QUEUE_DEPTH + EXTRA_BYTES; i++) begin
			read_word(UART_DATA_ADDR, rdat);
			exp_byte = expected_rx.pop_front();
			check_value($sformatf("byte %0d", i), DATA_W'(exp_byte), rdat);
		end
		read_word(UART_DATA_ADDR, rdat);
		check_value("read after drain", '0, rdat);

		test_name = "bus_safety";
		send_to_uart(8'h3C);
		wait_rx_left(0);
		// Reset lands while the next byte is read from the chip
		send_to_uart(8'hC3);
		while (uart_rd_n !== 1'b0)
			@(negedge clk);
		tbre = 1'b1;
		expected_rx.delete();
		repeat (3) @(negedge clk);
		check_value("strobes in reset", 5'b11111,
			DATA_W'({ram_en_n, ram_oe_n, ram_we_n, uart_rd_n, uart_wr_n}));
		tbre = 1'b0;
		read_word(UART_STAT_ADDR, rdat);
		check_value("status after reset", status_word(expected_rx.size() > 0, 1'b1), rdat);

		@(negedge clk);
		$display("Summary: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* compile.f */
design/mem_pkg.sv
design/uart_pkg.sv
design/wb_if.sv
design/rxq_if.sv
design/rx_queue.sv
design/bus_sequencer.sv
design/mem_uart_top.sv
verif/board_model.sv
verif/tb_mem_uart.sv
